//--- src/csrPkg.sv
package csrPkg;

    // core data widths
    localparam int XLEN = 32;
    localparam int TIMER_N = 20;
    localparam int NUM_HWINT = 8;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [13:0]     csrNum_t;
    typedef logic [5:0]      ecode_t;
    typedef logic [8:0]      esubcode_t;
    typedef logic [1:0]      plv_t;

    // csr numbers
    localparam csrNum_t CSR_CRMD   = 14'h000;
    localparam csrNum_t CSR_PRMD   = 14'h001;
    localparam csrNum_t CSR_ECFG   = 14'h004;
    localparam csrNum_t CSR_ESTAT  = 14'h005;
    localparam csrNum_t CSR_ERA    = 14'h006;
    localparam csrNum_t CSR_EENTRY = 14'h00c;
    localparam csrNum_t CSR_SAVE0  = 14'h030;
    localparam csrNum_t CSR_SAVE1  = 14'h031;
    localparam csrNum_t CSR_SAVE2  = 14'h032;
    localparam csrNum_t CSR_SAVE3  = 14'h033;
    localparam csrNum_t CSR_TID    = 14'h040;
    localparam csrNum_t CSR_TCFG   = 14'h041;
    localparam csrNum_t CSR_TVAL   = 14'h042;
    localparam csrNum_t CSR_TICLR  = 14'h044;

    localparam ecode_t ECODE_INT = 6'h00;

    // software-writable bits per register
    localparam xlen_t CRMD_WMASK   = 32'h0000_0007;
    localparam xlen_t PRMD_WMASK   = 32'h0000_0007;
    localparam xlen_t ECFG_WMASK   = 32'h0000_1bff;
    localparam xlen_t ESTAT_WMASK  = 32'h0000_0003;
    localparam xlen_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam xlen_t TCFG_WMASK   = xlen_t'({(TIMER_N + 2){1'b1}});

    typedef enum logic [2:0] {
        NONE,
        RD,
        WR,
        XCHG,
        ERTN,
        IDLE,
        EXCP
    } csrOp_t;

    typedef enum logic {
        RUN,
        IDLE_WAIT
    } ctrlState_t;

    // request from the pipeline
    typedef struct packed {
        logic      valid;
        csrOp_t    op;
        csrNum_t   num;
        xlen_t     wdata;
        xlen_t     mask;
        pc_t       pc;
        ecode_t    ecode;
        esubcode_t esubcode;
    } csrReq_t;

    typedef struct packed {
        logic    en;
        csrNum_t num;
        xlen_t   data;
        xlen_t   mask;
    } csrWrite_t;

    // trap entry or return
    typedef struct packed {
        logic      enter;
        logic      ret;
        ecode_t    ecode;
        esubcode_t esubcode;
        pc_t       pc;
    } trapEvt_t;

    typedef struct packed {
        logic               en;
        logic               periodic;
        logic [TIMER_N-1:0] initVal;
    } timerCfg_t;

endpackage

//--- src/csrControl.sv
module csrControl (
    input  logic               clk,
    input  logic               rstn,
    input  csrPkg::csrReq_t    req,
    input  logic               stall,
    input  logic               flush,
    input  logic               intReq,
    input  csrPkg::pc_t        eentry,
    input  csrPkg::pc_t        era,
    output csrPkg::csrWrite_t  wr,
    output csrPkg::trapEvt_t   trap,
    output logic               busy,
    output logic               flushOut,
    output logic               clkStall,
    output csrPkg::pc_t        redirectPc
);

    csrPkg::ctrlState_t state;
    csrPkg::ctrlState_t nextState;
    logic               accept;

    // pipeline back-pressure blocks execution, never interrupts
    assign accept = req.valid && !stall && !flush;

    always_comb
    begin
        wr         = '0;
        trap       = '0;
        flushOut   = 1'b0;
        redirectPc = eentry;
        nextState  = state;

        // write payload follows the request directly
        wr.num  = req.num;
        wr.data = req.wdata;

        case (state)
            csrPkg::RUN:
            begin
                if (intReq)
                begin
                    // request is dropped, pipeline replays it after return
                    trap.enter    = 1'b1;
                    trap.ecode    = csrPkg::ECODE_INT;
                    trap.esubcode = '0;
                    trap.pc       = req.pc;
                    flushOut      = 1'b1;
                end
                else if (accept)
                begin
                    case (req.op)
                        csrPkg::WR:
                        begin
                            wr.en   = 1'b1;
                            wr.mask = '1;
                        end
                        csrPkg::XCHG:
                        begin
                            wr.en   = 1'b1;
                            wr.mask = req.mask;
                        end
                        csrPkg::ERTN:
                        begin
                            trap.ret   = 1'b1;
                            flushOut   = 1'b1;
                            redirectPc = era;
                        end
                        csrPkg::EXCP:
                        begin
                            trap.enter    = 1'b1;
                            trap.ecode    = req.ecode;
                            trap.esubcode = req.esubcode;
                            trap.pc       = req.pc;
                            flushOut      = 1'b1;
                        end
                        csrPkg::IDLE:
                        begin
                            nextState = csrPkg::IDLE_WAIT;
                        end
                        // rd only reads, none does nothing
                        default:
                        begin
                        end
                    endcase
                end
            end
            csrPkg::IDLE_WAIT:
            begin
                // wake up, the trap itself is taken back in RUN
                if (intReq)
                begin
                    nextState = csrPkg::RUN;
                end
            end
            default:
            begin
                nextState = csrPkg::RUN;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= csrPkg::RUN;
        end
        else
        begin
            state <= nextState;
        end
    end

    // core stays frozen for the whole idle period
    assign busy     = (state == csrPkg::IDLE_WAIT);
    assign clkStall = (state == csrPkg::IDLE_WAIT);

endmodule

//--- src/csrRegFile.sv
module csrRegFile (
    input  logic                            clk,
    input  logic                            rstn,
    input  csrPkg::csrWrite_t               wr,
    input  csrPkg::trapEvt_t                trap,
    input  csrPkg::csrNum_t                 rdNum,
    input  logic [csrPkg::NUM_HWINT-1:0]    hwInt,
    input  logic                            tiSet,
    input  logic [csrPkg::TIMER_N-1:0]      tval,
    output csrPkg::xlen_t                   rdata,
    output logic                            intReq,
    output csrPkg::pc_t                     eentry,
    output csrPkg::pc_t                     era,
    output csrPkg::timerCfg_t               tcfg,
    output logic                            tcfgLoad
);

    csrPkg::xlen_t crmd;
    csrPkg::xlen_t prmd;
    csrPkg::xlen_t ecfg;
    csrPkg::xlen_t eraReg;
    csrPkg::xlen_t eentryReg;
    csrPkg::xlen_t tid;
    csrPkg::xlen_t tcfgReg;
    csrPkg::xlen_t save [4];

    // only the sw bits of estat are writable
    logic [1:0]                  isSw;
    logic [csrPkg::NUM_HWINT-1:0] isHw;
    logic                        isTi;
    csrPkg::ecode_t              ecode;
    csrPkg::esubcode_t           esubcode;

    csrPkg::xlen_t estatWord;
    csrPkg::xlen_t tvalWord;
    logic          tiClr;

    function automatic csrPkg::xlen_t merge(
        input csrPkg::xlen_t oldVal,
        input csrPkg::xlen_t wmask
    );
        csrPkg::xlen_t m;
        m = wr.mask & wmask;
        return (oldVal & ~m) | (wr.data & m);
    endfunction

    assign estatWord = {1'b0, esubcode, ecode, 3'b000, 1'b0, isTi, 1'b0, isHw, isSw};
    assign tvalWord  = {{(csrPkg::XLEN - csrPkg::TIMER_N){1'b0}}, tval};

    // ticlr bit 0 acks the timer interrupt
    assign tiClr = wr.en && (wr.num == csrPkg::CSR_TICLR) && wr.data[0] && wr.mask[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd      <= '0;
            prmd      <= '0;
            ecfg      <= '0;
            eraReg    <= '0;
            eentryReg <= '0;
            tid       <= '0;
            tcfgReg   <= '0;
            for (int i = 0; i < 4; i++)
            begin
                save[i] <= '0;
            end
            isSw      <= '0;
            isHw      <= '0;
            isTi      <= 1'b0;
            ecode     <= '0;
            esubcode  <= '0;
            tcfgLoad  <= 1'b0;
        end
        else
        begin
            isHw     <= hwInt;
            isTi     <= (isTi & ~tiClr) | tiSet;
            tcfgLoad <= 1'b0;

            if (wr.en)
            begin
                case (wr.num)
                    csrPkg::CSR_CRMD:   crmd      <= merge(crmd, csrPkg::CRMD_WMASK);
                    csrPkg::CSR_PRMD:   prmd      <= merge(prmd, csrPkg::PRMD_WMASK);
                    csrPkg::CSR_ECFG:   ecfg      <= merge(ecfg, csrPkg::ECFG_WMASK);
                    csrPkg::CSR_ESTAT:  isSw      <= 2'(merge(estatWord, csrPkg::ESTAT_WMASK));
                    csrPkg::CSR_ERA:    eraReg    <= merge(eraReg, '1);
                    csrPkg::CSR_EENTRY: eentryReg <= merge(eentryReg, csrPkg::EENTRY_WMASK);
                    csrPkg::CSR_TID:    tid       <= merge(tid, '1);
                    csrPkg::CSR_SAVE0,
                    csrPkg::CSR_SAVE1,
                    csrPkg::CSR_SAVE2,
                    csrPkg::CSR_SAVE3:
                    begin
                        save[wr.num[1:0]] <= merge(save[wr.num[1:0]], '1);
                    end
                    csrPkg::CSR_TCFG:
                    begin
                        tcfgReg  <= merge(tcfgReg, csrPkg::TCFG_WMASK);
                        tcfgLoad <= 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            end

            if (trap.enter)
            begin
                // save plv and ie and drop to kernel with interrupts off
                prmd[2:0] <= crmd[2:0];
                crmd[2:0] <= 3'b000;
                eraReg    <= trap.pc;
                ecode     <= trap.ecode;
                esubcode  <= trap.esubcode;
            end
            else if (trap.ret)
            begin
                crmd[2:0] <= prmd[2:0];
            end
        end
    end

    always_comb
    begin
        case (rdNum)
            csrPkg::CSR_CRMD:   rdata = crmd;
            csrPkg::CSR_PRMD:   rdata = prmd;
            csrPkg::CSR_ECFG:   rdata = ecfg;
            csrPkg::CSR_ESTAT:  rdata = estatWord;
            csrPkg::CSR_ERA:    rdata = eraReg;
            csrPkg::CSR_EENTRY: rdata = eentryReg;
            csrPkg::CSR_SAVE0:  rdata = save[0];
            csrPkg::CSR_SAVE1:  rdata = save[1];
            csrPkg::CSR_SAVE2:  rdata = save[2];
            csrPkg::CSR_SAVE3:  rdata = save[3];
            csrPkg::CSR_TID:    rdata = tid;
            csrPkg::CSR_TCFG:   rdata = tcfgReg;
            csrPkg::CSR_TVAL:   rdata = tvalWord;
            default:            rdata = '0;
        endcase
    end

    // lie masks IS and crmd.ie gates the lot
    assign intReq = (|(estatWord[12:0] & ecfg[12:0])) && crmd[2];

    assign eentry = eentryReg;
    assign era    = eraReg;

    assign tcfg.en       = tcfgReg[0];
    assign tcfg.periodic = tcfgReg[1];
    assign tcfg.initVal  = tcfgReg[csrPkg::TIMER_N+1:2];

endmodule

//--- src/csrTimer.sv
module csrTimer (
    input  logic                       clk,
    input  logic                       rstn,
    input  csrPkg::timerCfg_t          cfg,
    input  logic                       load,
    output logic [csrPkg::TIMER_N-1:0] tval,
    output logic                       tiSet
);

    logic lastTick;
    logic reload;

    // about to hit zero this cycle
    assign lastTick = cfg.en && (tval == csrPkg::TIMER_N'(1));

    // periodic mode restarts once the count sits at zero
    assign reload = cfg.en && cfg.periodic && (tval == '0);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval  <= '0;
            tiSet <= 1'b0;
        end
        else
        begin
            tiSet <= 1'b0;
            if (load)
            begin
                tval <= cfg.initVal;
            end
            else if (reload)
            begin
                tval <= cfg.initVal;
            end
            else if (cfg.en && (tval != '0))
            begin
                tval  <= tval - 1'b1;
                // one pulse per expiry
                tiSet <= lastTick;
            end
        end
    end

endmodule

//--- src/csrUnit.sv
module csrUnit (
    input  logic                         clk,
    input  logic                         rstn,
    input  csrPkg::csrReq_t              req,
    input  logic                         stall,
    input  logic                         flush,
    input  logic [csrPkg::NUM_HWINT-1:0] hwInt,
    output csrPkg::xlen_t                rdata,
    output logic                         stallOut,
    output logic                         flushOut,
    output logic                         clkStall,
    output csrPkg::pc_t                  redirectPc
);

    csrPkg::csrWrite_t          wr;
    csrPkg::trapEvt_t           trap;
    logic                       intReq;
    csrPkg::pc_t                eentry;
    csrPkg::pc_t                era;
    csrPkg::timerCfg_t          tcfg;
    logic                       tcfgLoad;
    logic [csrPkg::TIMER_N-1:0] tval;
    logic                       tiSet;

    csrControl uControl (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .intReq     (intReq),
        .eentry     (eentry),
        .era        (era),
        .wr         (wr),
        .trap       (trap),
        .busy       (stallOut),
        .flushOut   (flushOut),
        .clkStall   (clkStall),
        .redirectPc (redirectPc)
    );

    // read port follows the request number every cycle
    csrRegFile uRegFile (
        .clk      (clk),
        .rstn     (rstn),
        .wr       (wr),
        .trap     (trap),
        .rdNum    (req.num),
        .hwInt    (hwInt),
        .tiSet    (tiSet),
        .tval     (tval),
        .rdata    (rdata),
        .intReq   (intReq),
        .eentry   (eentry),
        .era      (era),
        .tcfg     (tcfg),
        .tcfgLoad (tcfgLoad)
    );

    csrTimer uTimer (
        .clk   (clk),
        .rstn  (rstn),
        .cfg   (tcfg),
        .load  (tcfgLoad),
        .tval  (tval),
        .tiSet (tiSet)
    );

endmodule

//--- sim/csrUnit_checker.sv
module csrUnitChecker (
    input logic               clk,
    input logic               rstn,
    input logic               stallOut,
    input logic               flushOut,
    input logic               clkStall,
    input csrPkg::pc_t        redirectPc,
    input csrPkg::pc_t        eentry,
    input csrPkg::trapEvt_t   trap
);

    // clkStall is high exactly in IDLE_WAIT
    assert property (@(posedge clk) disable iff (!rstn) clkStall |-> !flushOut)
        else $error("flush raised during idle wait");

    assert property (@(posedge clk) disable iff (!rstn) trap.enter |-> redirectPc == eentry)
        else $error("trap entry redirect differs from eentry");

    assert property (@(posedge clk) disable iff (!rstn) clkStall |-> stallOut)
        else $error("clkStall high without stallOut");

    assert property (@(posedge clk) $rose(rstn) |=> !stallOut && !flushOut && !clkStall)
        else $error("stall, flush or clkStall high right after reset");

endmodule

bind csrUnit csrUnitChecker uChecker (
    .clk        (clk),
    .rstn       (rstn),
    .stallOut   (stallOut),
    .flushOut   (flushOut),
    .clkStall   (clkStall),
    .redirectPc (redirectPc),
    .eentry     (eentry),
    .trap       (trap)
);

//--- sim/csrUnitTb.sv
module csrUnitTb;

    localparam int RESET_CYCLES = 4;
    // rough cycle budget per test
    localparam int RW_CYCLES    = 80;
    localparam int XCHG_CYCLES  = 40;
    localparam int TRAP_CYCLES  = 40;
    localparam int INT_CYCLES   = 60;
    localparam int TIMER_CYCLES = 300;
    localparam int IDLE_CYCLES  = 60;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RW_CYCLES + XCHG_CYCLES + TRAP_CYCLES
                                   + INT_CYCLES + TIMER_CYCLES + IDLE_CYCLES + 200;
    localparam csrPkg::pc_t HANDLER = 32'h1c00_8040;

    logic                         clk;
    logic                         rstn;
    csrPkg::csrReq_t              req;
    logic                         stall;
    logic                         flush;
    logic [csrPkg::NUM_HWINT-1:0] hwInt;
    csrPkg::xlen_t                rdata;
    logic                         stallOut;
    logic                         flushOut;
    logic                         clkStall;
    csrPkg::pc_t                  redirectPc;

    int            errors;
    int            checks;
    logic [31:0]   lcgState;
    // outputs captured in the accepting cycle
    csrPkg::xlen_t seenData;
    logic          seenFlush;
    csrPkg::pc_t   seenPc;

    csrUnit DUT (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .hwInt      (hwInt),
        .rdata      (rdata),
        .stallOut   (stallOut),
        .flushOut   (flushOut),
        .clkStall   (clkStall),
        .redirectPc (redirectPc)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkData(input string name, input csrPkg::xlen_t got,
                             input csrPkg::xlen_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkPc(input string name, input csrPkg::pc_t got, input csrPkg::pc_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one accepted request with valid dropped at the next falling edge
    task automatic sendReq(input csrPkg::csrOp_t op, input csrPkg::csrNum_t num,
                           input csrPkg::xlen_t data, input csrPkg::xlen_t mask,
                           input csrPkg::pc_t pc);
        @(negedge clk);
        req.valid = 1'b1;
        req.op    = op;
        req.num   = num;
        req.wdata = data;
        req.mask  = mask;
        req.pc    = pc;
        #1;
        seenData  = rdata;
        seenFlush = flushOut;
        seenPc    = redirectPc;
        @(negedge clk);
        req.valid = 1'b0;
        req.op    = csrPkg::NONE;
    endtask

    task automatic writeCsr(input csrPkg::csrNum_t num, input csrPkg::xlen_t data);
        sendReq(csrPkg::WR, num, data, '0, req.pc);
    endtask

    task automatic readCsr(input csrPkg::csrNum_t num, output csrPkg::xlen_t value);
        sendReq(csrPkg::RD, num, '0, '0, req.pc);
        value = seenData;
    endtask

    // starts looking in the current cycle
    task automatic waitFlush(input int limit);
        int n;
        n = 0;
        seenFlush = 1'b0;
        while (!seenFlush && n < limit)
        begin
            #1;
            seenFlush = flushOut;
            seenPc    = redirectPc;
            if (!seenFlush)
            begin
                @(negedge clk);
                n++;
            end
        end
        checks++;
        if (!seenFlush)
        begin
            errors++;
            $display("no flush seen within %0d cycles", limit);
        end
    endtask

    task automatic waitTimerIrq(input int limit);
        csrPkg::xlen_t value;
        int            n;
        value = '0;
        n = 0;
        while (!value[11] && n < limit)
        begin
            readCsr(csrPkg::CSR_ESTAT, value);
            n++;
        end
        checks++;
        if (!value[11])
        begin
            errors++;
            $display("timer interrupt bit never set after %0d reads", limit);
        end
    endtask

    task automatic testResetAndRw();
        csrPkg::csrNum_t allRegs [13];
        csrPkg::csrNum_t rwRegs [6];
        csrPkg::xlen_t   value;
        csrPkg::xlen_t   data;
        allRegs = '{csrPkg::CSR_CRMD, csrPkg::CSR_PRMD, csrPkg::CSR_ECFG, csrPkg::CSR_ESTAT,
                    csrPkg::CSR_ERA, csrPkg::CSR_EENTRY, csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1,
                    csrPkg::CSR_SAVE2, csrPkg::CSR_SAVE3, csrPkg::CSR_TID, csrPkg::CSR_TCFG,
                    csrPkg::CSR_TVAL};
        rwRegs = '{csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1, csrPkg::CSR_SAVE2, csrPkg::CSR_SAVE3,
                   csrPkg::CSR_ERA, csrPkg::CSR_EENTRY};
        foreach (allRegs[i])
        begin
            readCsr(allRegs[i], value);
            checkData($sformatf("rdata csr 0x%h after reset", allRegs[i]), value, '0);
        end
        foreach (rwRegs[i])
        begin
            data = nextRand();
            writeCsr(rwRegs[i], data);
            readCsr(rwRegs[i], value);
            // eentry is 64-byte aligned
            if (rwRegs[i] == csrPkg::CSR_EENTRY)
            begin
                data[5:0] = 6'h00;
            end
            checkData($sformatf("rdata csr 0x%h readback", rwRegs[i]), value, data);
        end
    endtask

    task automatic testXchg();
        csrPkg::xlen_t base;
        csrPkg::xlen_t data;
        csrPkg::xlen_t mask;
        csrPkg::xlen_t value;
        base = nextRand();
        data = nextRand();
        mask = nextRand();
        writeCsr(csrPkg::CSR_SAVE1, base);
        sendReq(csrPkg::XCHG, csrPkg::CSR_SAVE1, data, mask, req.pc);
        checkData("rdata xchg old save1", seenData, base);
        readCsr(csrPkg::CSR_SAVE1, value);
        checkData("rdata save1 after xchg", value, (base & ~mask) | (data & mask));
        // only plv and ie stick
        writeCsr(csrPkg::CSR_CRMD, 32'hffff_fffb);
        readCsr(csrPkg::CSR_CRMD, value);
        checkData("rdata crmd", value, 32'h0000_0003);
        writeCsr(csrPkg::CSR_ESTAT, 32'hffff_ffff);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkData("rdata estat", value, 32'h0000_0003);
        writeCsr(csrPkg::CSR_ESTAT, '0);
        writeCsr(14'h3ff, nextRand());
        readCsr(14'h3ff, value);
        checkData("rdata unknown csr", value, '0);
    endtask

    task automatic testTrap();
        csrPkg::xlen_t value;
        writeCsr(csrPkg::CSR_EENTRY, HANDLER);
        req.ecode    = 6'h0b;
        req.esubcode = 9'h005;
        sendReq(csrPkg::EXCP, '0, '0, '0, 32'h1c00_1234);
        checkBit("flushOut on excp", seenFlush, 1'b1);
        checkPc("redirectPc on excp", seenPc, HANDLER);
        readCsr(csrPkg::CSR_PRMD, value);
        checkData("rdata prmd after excp", value, 32'h0000_0003);
        readCsr(csrPkg::CSR_CRMD, value);
        checkData("rdata crmd after excp", value, '0);
        readCsr(csrPkg::CSR_ERA, value);
        checkData("rdata era after excp", value, 32'h1c00_1234);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkData("rdata estat after excp", value, (32'h005 << 22) | (32'h0b << 16));
        sendReq(csrPkg::ERTN, '0, '0, '0, 32'h1c00_2000);
        checkBit("flushOut on ertn", seenFlush, 1'b1);
        checkPc("redirectPc on ertn", seenPc, 32'h1c00_1234);
        readCsr(csrPkg::CSR_CRMD, value);
        checkData("rdata crmd after ertn", value, 32'h0000_0003);
        writeCsr(csrPkg::CSR_CRMD, '0);
    endtask

    task automatic testInterrupt();
        csrPkg::pc_t   intPc;
        csrPkg::xlen_t value;
        intPc = 32'h1c00_3000;
        writeCsr(csrPkg::CSR_ECFG, 32'h1);
        writeCsr(csrPkg::CSR_ESTAT, 32'h1);
        sendReq(csrPkg::RD, csrPkg::CSR_SAVE0, '0, '0, intPc);
        checkBit("flushOut with ie clear", seenFlush, 1'b0);
        repeat (3)
        begin
            #1;
            checkBit("flushOut with ie clear", flushOut, 1'b0);
            @(negedge clk);
        end
        writeCsr(csrPkg::CSR_CRMD, 32'h4);
        waitFlush(4);
        checkPc("redirectPc on interrupt", seenPc, HANDLER);
        readCsr(csrPkg::CSR_ERA, value);
        checkData("rdata era after interrupt", value, intPc);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkData("rdata estat after interrupt", value, 32'h0000_0001);
        writeCsr(csrPkg::CSR_ESTAT, '0);
        sendReq(csrPkg::ERTN, '0, '0, '0, intPc);
        checkPc("redirectPc on ertn", seenPc, intPc);
        repeat (5)
        begin
            #1;
            checkBit("flushOut after ertn", flushOut, 1'b0);
            @(negedge clk);
        end
        readCsr(csrPkg::CSR_CRMD, value);
        checkData("rdata crmd after ertn", value, 32'h0000_0004);
        writeCsr(csrPkg::CSR_CRMD, '0);
        writeCsr(csrPkg::CSR_ECFG, '0);
    endtask

    task automatic testTimer();
        csrPkg::xlen_t value;
        csrPkg::xlen_t prev;
        int            n;
        // one-shot with initVal 20
        writeCsr(csrPkg::CSR_TCFG, (32'd20 << 2) | 32'h1);
        readCsr(csrPkg::CSR_TVAL, value);
        checkBit("tval loaded nonzero", value != 0, 1'b1);
        prev = value;
        n = 0;
        while (value != 0 && n < 40)
        begin
            readCsr(csrPkg::CSR_TVAL, value);
            checks++;
            if (value > prev)
            begin
                errors++;
                $display("[ERROR] rdata tval rose: got 0x%h after 0x%h", value, prev);
            end
            prev = value;
            n++;
        end
        checkData("rdata tval at end", value, '0);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkBit("estat is11 after expiry", value[11], 1'b1);
        repeat (4) @(negedge clk);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkBit("estat is11 held", value[11], 1'b1);
        writeCsr(csrPkg::CSR_TICLR, 32'h1);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkBit("estat is11 after ticlr", value[11], 1'b0);
        readCsr(csrPkg::CSR_TVAL, value);
        checkData("rdata tval one-shot stopped", value, '0);
        // periodic mode with a period long enough to clear between expiries
        writeCsr(csrPkg::CSR_TCFG, (32'd16 << 2) | 32'h3);
        waitTimerIrq(40);
        writeCsr(csrPkg::CSR_TICLR, 32'h1);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkBit("estat is11 periodic clear", value[11], 1'b0);
        waitTimerIrq(40);
        writeCsr(csrPkg::CSR_TCFG, '0);
        writeCsr(csrPkg::CSR_TICLR, 32'h1);
    endtask

    task automatic testIdle();
        csrPkg::pc_t   idlePc;
        csrPkg::xlen_t value;
        idlePc = 32'h1c00_4000;
        // leave a nonzero ecode behind for the wake trap to overwrite
        req.ecode    = 6'h07;
        req.esubcode = 9'h003;
        sendReq(csrPkg::EXCP, '0, '0, '0, 32'h1c00_4100);
        writeCsr(csrPkg::CSR_ECFG, 32'h4);
        writeCsr(csrPkg::CSR_CRMD, 32'h4);
        sendReq(csrPkg::IDLE, '0, '0, '0, idlePc);
        repeat (5)
        begin
            #1;
            checkBit("stallOut in idle", stallOut, 1'b1);
            checkBit("clkStall in idle", clkStall, 1'b1);
            @(negedge clk);
        end
        hwInt = 8'h01;
        waitFlush(8);
        checkPc("redirectPc on wake", seenPc, HANDLER);
        checkBit("stallOut on wake", stallOut, 1'b0);
        readCsr(csrPkg::CSR_ERA, value);
        checkData("rdata era after wake", value, idlePc);
        readCsr(csrPkg::CSR_ESTAT, value);
        checkData("rdata estat after wake", value, 32'h0000_0004);
        hwInt = '0;
        writeCsr(csrPkg::CSR_ECFG, '0);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        errors   = 0;
        checks   = 0;
        lcgState = 32'h4dd;
        rstn     = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        hwInt    = '0;
        req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        testResetAndRw();
        testXchg();
        testTrap();
        testInterrupt();
        testTimer();
        testIdle();

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- csrUnit.f
src/csrPkg.sv
src/csrControl.sv
src/csrRegFile.sv
src/csrTimer.sv
src/csrUnit.sv
sim/csrUnit_checker.sv
sim/csrUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csrUnitTb
FILELIST  ?= csrUnit.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

PASS_MSG := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
